/* all.f */
+incdir+.
cluster_bus_pkg.sv
rr_arbiter.sv
bus_spill_reg.sv
cluster_addr_decoder.sv
cluster_bus_xbar.sv
cluster_bus_wrap.sv
tb_target_model.sv
cluster_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cluster bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cluster_bus_tb \
  -f all.f -o cluster_bus_sim &&
  ./obj_dir/cluster_bus_sim | tee /dev/stderr | grep -q "All tests passed" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* cluster_bus_tb.sv */
// cluster bus testbench
// table driven accesses from the four initiators into three target models
`timescale 1ns/1ps
`default_nettype none
`include "cluster_bus_defs.svh"

module cluster_bus_tb;
  import cluster_bus_pkg::*;

  localparam int NROWS = 21;
  localparam int LIMIT = NROWS * 40 + 100;
  localparam int HOLD_CYCLES = 6;

  // exp is the target index or 3 for a decode error
  typedef struct {
    string       name;
    int          grp;
    logic [5:0]  cid;
    int          init;
    logic [31:0] addr;
    bit          we;
    int          exp;
    bit          hold;
  } row_t;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic [5:0]  cluster_id;
  init_req_t   req [4];
  logic        req_valid [4];
  logic        req_ready [4];
  init_rsp_t   rsp [4];
  logic        rsp_valid [4];
  logic        rsp_ready [4];
  tgt_req_t    tgt_req [3];
  logic        tgt_valid [3];
  logic        tgt_ready [3];
  tgt_rsp_t    tgt_rsp [3];
  logic        tgt_rsp_valid [3];
  logic        tgt_rsp_ready [3];
  logic [2:0]  hold_tgt;
  logic [2:0]  lcg_stall;
  logic [2:0]  tgt_stall;

  row_t        rows [NROWS];
  int          row_err [NROWS];
  bit          active [4];
  bit          rsp_got [4];
  int          cur_row [4];
  int          sent_cnt [4];
  int          rsp_cnt [4];
  int          tgt_cnt [3];
  bit          seen [3][4];
  int          mon_errs;
  int          cycles;
  logic [31:0] lcg_state;
  bit          first_cycle;
  tgt_req_t    prev_req [3];
  bit          prev_stuck [3];

  cluster_bus_wrap u_cluster_bus_wrap (
    .clk_i (clk_i), .rst_i (rst_i), .cluster_id_i (cluster_id),
    .ext_slv_req_i (req[0]), .ext_slv_req_valid_i (req_valid[0]),
    .ext_slv_req_ready_o (req_ready[0]), .ext_slv_rsp_o (rsp[0]),
    .ext_slv_rsp_valid_o (rsp_valid[0]), .ext_slv_rsp_ready_i (rsp_ready[0]),
    .dma_slv_req_i (req[1]), .dma_slv_req_valid_i (req_valid[1]),
    .dma_slv_req_ready_o (req_ready[1]), .dma_slv_rsp_o (rsp[1]),
    .dma_slv_rsp_valid_o (rsp_valid[1]), .dma_slv_rsp_ready_i (rsp_ready[1]),
    .data_slv_req_i (req[2]), .data_slv_req_valid_i (req_valid[2]),
    .data_slv_req_ready_o (req_ready[2]), .data_slv_rsp_o (rsp[2]),
    .data_slv_rsp_valid_o (rsp_valid[2]), .data_slv_rsp_ready_i (rsp_ready[2]),
    .instr_slv_req_i (req[3]), .instr_slv_req_valid_i (req_valid[3]),
    .instr_slv_req_ready_o (req_ready[3]), .instr_slv_rsp_o (rsp[3]),
    .instr_slv_rsp_valid_o (rsp_valid[3]), .instr_slv_rsp_ready_i (rsp_ready[3]),
    .tcdm_mst_req_o (tgt_req[0]), .tcdm_mst_req_valid_o (tgt_valid[0]),
    .tcdm_mst_req_ready_i (tgt_ready[0]), .tcdm_mst_rsp_i (tgt_rsp[0]),
    .tcdm_mst_rsp_valid_i (tgt_rsp_valid[0]), .tcdm_mst_rsp_ready_o (tgt_rsp_ready[0]),
    .periph_mst_req_o (tgt_req[1]), .periph_mst_req_valid_o (tgt_valid[1]),
    .periph_mst_req_ready_i (tgt_ready[1]), .periph_mst_rsp_i (tgt_rsp[1]),
    .periph_mst_rsp_valid_i (tgt_rsp_valid[1]), .periph_mst_rsp_ready_o (tgt_rsp_ready[1]),
    .ext_mst_req_o (tgt_req[2]), .ext_mst_req_valid_o (tgt_valid[2]),
    .ext_mst_req_ready_i (tgt_ready[2]), .ext_mst_rsp_i (tgt_rsp[2]),
    .ext_mst_rsp_valid_i (tgt_rsp_valid[2]), .ext_mst_rsp_ready_o (tgt_rsp_ready[2])
  );

  for (genvar t = 0; t < 3; t++) begin : gen_model
    assign tgt_stall[t] = hold_tgt[t] | lcg_stall[t];
    tb_target_model #(.TAG(t), .LATENCY(2)) u_model (
      .clk_i (clk_i), .rst_i (rst_i), .stall_i (tgt_stall[t]),
      .req_i (tgt_req[t]), .req_valid_i (tgt_valid[t]), .req_ready_o (tgt_ready[t]),
      .rsp_o (tgt_rsp[t]), .rsp_valid_o (tgt_rsp_valid[t]), .rsp_ready_i (tgt_rsp_ready[t])
    );
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  // roughly one stall cycle in four per target
  always @(posedge clk_i) begin
    #1;
    for (int t = 0; t < 3; t++) begin
      lcg_stall[t] = (lcg_next() >> 19) % 4 == 0;
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  // bus monitor sampled mid-cycle while all signals are stable
  always @(negedge clk_i) begin
    if (rst_i || first_cycle) begin
      for (int t = 0; t < 3; t++) begin
        assert (!tgt_valid[t]) else begin
          $display("target %0d request valid is high around reset", t);
          mon_errs++;
        end
      end
      for (int i = 0; i < 4; i++) begin
        assert (!rsp_valid[i]) else begin
          $display("initiator %0d response valid is high around reset", i);
          mon_errs++;
        end
      end
    end
    first_cycle = rst_i;
    for (int t = 0; t < 3; t++) begin
      if (prev_stuck[t]) begin
        assert (tgt_valid[t] && tgt_req[t] == prev_req[t]) else begin
          $display("target %0d request changed or dropped while stalled", t);
          mon_errs++;
        end
      end
      prev_stuck[t] = tgt_valid[t] && !tgt_ready[t];
      prev_req[t] = tgt_req[t];
      if (tgt_valid[t] && tgt_ready[t]) begin
        int idx;
        logic [`CB_ADDR_W+`CB_DATA_W+4:0] exp_pl;
        logic [`CB_ADDR_W+`CB_DATA_W+4:0] act_pl;
        idx = tgt_req[t].id[5:4];
        tgt_cnt[t]++;
        assert (active[idx] && rows[cur_row[idx]].exp == t &&
                tgt_req[t].id[3:0] == 4'(cur_row[idx])) else begin
          $display("target %0d got unexpected request with ID %h", t, tgt_req[t].id);
          mon_errs++;
        end
        if (active[idx]) begin
          // address, write enable, write data and byte enable as issued
          exp_pl = {rows[cur_row[idx]].addr, rows[cur_row[idx]].we, req[idx].wdata, 4'hf};
          act_pl = {tgt_req[t].addr, tgt_req[t].we, tgt_req[t].wdata, tgt_req[t].be};
          assert (act_pl == exp_pl) else begin
            $display("MISMATCH %s target payload expected %h actual %h",
                     rows[cur_row[idx]].name, exp_pl, act_pl);
            row_err[cur_row[idx]]++;
          end
        end
        assert (!seen[t][idx]) else begin
          $display("target %0d saw initiator %0d twice in one burst", t, idx);
          mon_errs++;
        end
        seen[t][idx] = 1'b1;
      end
    end
    for (int i = 0; i < 4; i++) begin
      if (rsp_valid[i] && rsp_ready[i]) begin
        rsp_cnt[i]++;
      end
    end
  end

  task automatic load_table();
    rows[0]  = '{"c0_tcdm_rd",    0, 6'd0, 2, 32'h1000_0100, 0, 0, 0};
    rows[1]  = '{"c0_tcdm_last",  1, 6'd0, 3, 32'h1000_ffff, 0, 0, 0};
    rows[2]  = '{"c0_periph",     2, 6'd0, 2, 32'h1020_0040, 0, 1, 0};
    rows[3]  = '{"c0_below",      3, 6'd0, 0, 32'h0fff_fffc, 0, 2, 0};
    rows[4]  = '{"c0_above",      4, 6'd0, 1, 32'h1040_0000, 0, 2, 0};
    rows[5]  = '{"c5_tcdm_rd",    5, 6'd5, 2, 32'h1140_0010, 0, 0, 0};
    rows[6]  = '{"c5_tcdm_last",  6, 6'd5, 1, 32'h1140_ffff, 0, 0, 0};
    rows[7]  = '{"c5_periph",     7, 6'd5, 3, 32'h1160_0000, 0, 1, 0};
    rows[8]  = '{"c5_below",      8, 6'd5, 0, 32'h113f_fffc, 0, 2, 0};
    rows[9]  = '{"c5_above",      9, 6'd5, 2, 32'h1180_0000, 0, 2, 0};
    rows[10] = '{"c0_hole",      10, 6'd0, 1, 32'h1001_0000, 0, 3, 0};
    rows[11] = '{"c5_hole",      11, 6'd5, 3, 32'h1150_0000, 0, 3, 0};
    rows[12] = '{"c0_tcdm_wr",   12, 6'd0, 0, 32'h1000_2000, 1, 0, 0};
    rows[13] = '{"cont_ext",     13, 6'd0, 0, 32'h1000_3000, 0, 0, 0};
    rows[14] = '{"cont_dma",     13, 6'd0, 1, 32'h1000_3004, 0, 0, 0};
    rows[15] = '{"cont_data",    13, 6'd0, 2, 32'h1000_3008, 1, 0, 0};
    rows[16] = '{"cont_instr",   13, 6'd0, 3, 32'h1000_300c, 0, 0, 0};
    rows[17] = '{"bp_ext",       14, 6'd0, 0, 32'h1020_1000, 0, 1, 1};
    rows[18] = '{"bp_dma",       14, 6'd0, 1, 32'h1020_1004, 1, 1, 1};
    rows[19] = '{"bp_data",      14, 6'd0, 2, 32'h1020_1008, 0, 1, 1};
    rows[20] = '{"bp_instr",     14, 6'd0, 3, 32'h2000_0000, 0, 2, 1};
  endtask

  // expected values follow the address map and the model's data rule
  task automatic check_response(input int i);
    int          r;
    logic [31:0] exp_data;
    logic        exp_err;
    r = cur_row[i];
    exp_err = rows[r].exp == 3;
    exp_data = (exp_err || rows[r].we) ? 32'h0 : rows[r].addr ^ (32'(rows[r].exp) << 30);
    assert (rsp[i].id == 4'(r)) else begin
      $display("MISMATCH %s id expected %h actual %h", rows[r].name, 4'(r), rsp[i].id);
      row_err[r]++;
    end
    assert (rsp[i].err == exp_err) else begin
      $display("MISMATCH %s err expected %h actual %h", rows[r].name, exp_err, rsp[i].err);
      row_err[r]++;
    end
    assert (rsp[i].rdata == exp_data) else begin
      $display("MISMATCH %s rdata expected %h actual %h", rows[r].name, exp_data,
               rsp[i].rdata);
      row_err[r]++;
    end
  endtask

  task automatic run_group(input int first, input int last);
    int  exp_cnt [3];
    int  base_cnt [3];
    int  n_left;
    int  hold_left;
    int  i;
    bit  taken [4];
    @(posedge clk_i);
    #1;
    cluster_id = rows[first].cid;
    exp_cnt = '{0, 0, 0};
    for (int t = 0; t < 3; t++) begin
      base_cnt[t] = tgt_cnt[t];
      for (int k = 0; k < 4; k++) begin
        seen[t][k] = 1'b0;
      end
    end
    for (int r = first; r <= last; r++) begin
      i = rows[r].init;
      req[i].addr = rows[r].addr;
      req[i].we = rows[r].we;
      req[i].wdata = rows[r].we ? lcg_next() : 32'h0;
      req[i].be = 4'hf;
      req[i].id = 4'(r);
      req_valid[i] = 1'b1;
      cur_row[i] = r;
      active[i] = 1'b1;
      rsp_got[i] = 1'b0;
      taken[i] = 1'b0;
      sent_cnt[i]++;
      if (rows[r].exp < 3) begin
        exp_cnt[rows[r].exp]++;
        if (rows[r].hold) begin
          hold_tgt[rows[r].exp] = 1'b1;
        end
      end
    end
    n_left = last - first + 1;
    hold_left = HOLD_CYCLES;
    while (n_left > 0) begin
      @(negedge clk_i);
      for (int k = 0; k < 4; k++) begin
        if (active[k] && req_valid[k] && req_ready[k]) begin
          taken[k] = 1'b1;
        end
        if (active[k] && !rsp_got[k] && rsp_valid[k]) begin
          check_response(k);
          rsp_got[k] = 1'b1;
          n_left--;
        end
      end
      @(posedge clk_i);
      #1;
      for (int k = 0; k < 4; k++) begin
        if (taken[k]) begin
          req_valid[k] = 1'b0;
        end
      end
      if (hold_left > 0) begin
        hold_left--;
      end else begin
        hold_tgt = '0;
      end
    end
    hold_tgt = '0;
    for (int t = 0; t < 3; t++) begin
      assert (tgt_cnt[t] - base_cnt[t] == exp_cnt[t]) else begin
        $display("MISMATCH %s target %0d requests expected %0d actual %0d",
                 rows[first].name, t, exp_cnt[t], tgt_cnt[t] - base_cnt[t]);
        row_err[first]++;
      end
    end
    for (int k = 0; k < 4; k++) begin
      active[k] = 1'b0;
    end
  endtask

  initial begin
    int r;
    int last;
    int fails;
    rst_i = 1'b1;
    cluster_id = '0;
    hold_tgt = '0;
    lcg_stall = '0;
    lcg_state = 32'd92309;
    mon_errs = 0;
    cycles = 0;
    first_cycle = 1'b0;
    fails = 0;
    for (int k = 0; k < 4; k++) begin
      req[k] = '0;
      req_valid[k] = 1'b0;
      rsp_ready[k] = 1'b1;
      active[k] = 1'b0;
      cur_row[k] = 0;
      sent_cnt[k] = 0;
      rsp_cnt[k] = 0;
    end
    for (int t = 0; t < 3; t++) begin
      tgt_cnt[t] = 0;
      prev_stuck[t] = 1'b0;
    end
    load_table();
    for (int k = 0; k < NROWS; k++) begin
      row_err[k] = 0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    r = 0;
    while (r < NROWS) begin
      last = r;
      while (last + 1 < NROWS && rows[last + 1].grp == rows[r].grp) begin
        last++;
      end
      run_group(r, last);
      for (int k = r; k <= last; k++) begin
        $display("%s %s", (row_err[k] == 0) ? "PASS" : "FAIL", rows[k].name);
        if (row_err[k] != 0) begin
          fails++;
        end
      end
      r = last + 1;
    end
    for (int k = 0; k < 4; k++) begin
      assert (rsp_cnt[k] == sent_cnt[k]) else begin
        $display("MISMATCH init%0d responses expected %0d actual %0d", k, sent_cnt[k],
                 rsp_cnt[k]);
        mon_errs++;
      end
    end
    $display("tests: %0d passed: %0d failed: %0d monitor errors: %0d",
             NROWS, NROWS - fails, fails, mon_errs);
    if (fails == 0 && mon_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_target_model.sv */
// testbench target model
// accepts requests unless stalled and answers each one after a fixed latency
`timescale 1ns/1ps
`default_nettype none
`include "cluster_bus_defs.svh"

module tb_target_model #(
  parameter int TAG = 0,
  parameter int LATENCY = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       stall_i,
  input  cluster_bus_pkg::tgt_req_t  req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  output cluster_bus_pkg::tgt_rsp_t  rsp_o,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i
);
  import cluster_bus_pkg::*;

  tgt_rsp_t pend_q[$];
  int       due_q[$];
  int       cyc;

  // read data carries the target tag in the top two bits
  function automatic tgt_rsp_t make_rsp(tgt_req_t req);
    tgt_rsp_t rsp;
    rsp.rdata = req.we ? '0 : (req.addr ^ (32'(TAG) << 30));
    rsp.err = 1'b0;
    rsp.id = req.id;
    return rsp;
  endfunction

  assign req_ready_o = !stall_i && !rst_i;

  initial begin
    rsp_o = '0;
    rsp_valid_o = 1'b0;
    cyc = 0;
  end

  // handshakes seen at the falling edge complete on the next rising edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      pend_q.delete();
      due_q.delete();
      cyc = 0;
    end else begin
      if (rsp_valid_o && rsp_ready_i) begin
        void'(pend_q.pop_front());
        void'(due_q.pop_front());
      end
      if (req_valid_i && req_ready_o) begin
        pend_q.push_back(make_rsp(req_i));
        due_q.push_back(cyc + LATENCY);
      end
      cyc = cyc + 1;
    end
  end

  always @(posedge clk_i) begin
    #1;
    if (pend_q.size() > 0 && due_q[0] <= cyc) begin
      rsp_valid_o = 1'b1;
      rsp_o = pend_q[0];
    end else begin
      rsp_valid_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* cluster_bus_wrap.sv */
// cluster bus top level
// maps the named initiator and target ports onto the crossbar port arrays
`timescale 1ns/1ps
`default_nettype none

module cluster_bus_wrap (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [5:0]                 cluster_id_i,
  // initiator ports
  input  cluster_bus_pkg::init_req_t ext_slv_req_i,
  input  logic                       ext_slv_req_valid_i,
  output logic                       ext_slv_req_ready_o,
  output cluster_bus_pkg::init_rsp_t ext_slv_rsp_o,
  output logic                       ext_slv_rsp_valid_o,
  input  logic                       ext_slv_rsp_ready_i,
  input  cluster_bus_pkg::init_req_t dma_slv_req_i,
  input  logic                       dma_slv_req_valid_i,
  output logic                       dma_slv_req_ready_o,
  output cluster_bus_pkg::init_rsp_t dma_slv_rsp_o,
  output logic                       dma_slv_rsp_valid_o,
  input  logic                       dma_slv_rsp_ready_i,
  input  cluster_bus_pkg::init_req_t data_slv_req_i,
  input  logic                       data_slv_req_valid_i,
  output logic                       data_slv_req_ready_o,
  output cluster_bus_pkg::init_rsp_t data_slv_rsp_o,
  output logic                       data_slv_rsp_valid_o,
  input  logic                       data_slv_rsp_ready_i,
  input  cluster_bus_pkg::init_req_t instr_slv_req_i,
  input  logic                       instr_slv_req_valid_i,
  output logic                       instr_slv_req_ready_o,
  output cluster_bus_pkg::init_rsp_t instr_slv_rsp_o,
  output logic                       instr_slv_rsp_valid_o,
  input  logic                       instr_slv_rsp_ready_i,
  // target ports
  output cluster_bus_pkg::tgt_req_t  tcdm_mst_req_o,
  output logic                       tcdm_mst_req_valid_o,
  input  logic                       tcdm_mst_req_ready_i,
  input  cluster_bus_pkg::tgt_rsp_t  tcdm_mst_rsp_i,
  input  logic                       tcdm_mst_rsp_valid_i,
  output logic                       tcdm_mst_rsp_ready_o,
  output cluster_bus_pkg::tgt_req_t  periph_mst_req_o,
  output logic                       periph_mst_req_valid_o,
  input  logic                       periph_mst_req_ready_i,
  input  cluster_bus_pkg::tgt_rsp_t  periph_mst_rsp_i,
  input  logic                       periph_mst_rsp_valid_i,
  output logic                       periph_mst_rsp_ready_o,
  output cluster_bus_pkg::tgt_req_t  ext_mst_req_o,
  output logic                       ext_mst_req_valid_o,
  input  logic                       ext_mst_req_ready_i,
  input  cluster_bus_pkg::tgt_rsp_t  ext_mst_rsp_i,
  input  logic                       ext_mst_rsp_valid_i,
  output logic                       ext_mst_rsp_ready_o
);

  // concatenations list the highest index first
  // initiators are ext 0, dma 1, data 2, instr 3
  // targets are tcdm 0, periph 1, ext 2
  cluster_bus_xbar u_xbar (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .cluster_id_i     (cluster_id_i),
    .init_req_i       ({instr_slv_req_i, data_slv_req_i, dma_slv_req_i, ext_slv_req_i}),
    .init_req_valid_i ({instr_slv_req_valid_i, data_slv_req_valid_i,
                        dma_slv_req_valid_i, ext_slv_req_valid_i}),
    .init_req_ready_o ({instr_slv_req_ready_o, data_slv_req_ready_o,
                        dma_slv_req_ready_o, ext_slv_req_ready_o}),
    .init_rsp_o       ({instr_slv_rsp_o, data_slv_rsp_o, dma_slv_rsp_o, ext_slv_rsp_o}),
    .init_rsp_valid_o ({instr_slv_rsp_valid_o, data_slv_rsp_valid_o,
                        dma_slv_rsp_valid_o, ext_slv_rsp_valid_o}),
    .init_rsp_ready_i ({instr_slv_rsp_ready_i, data_slv_rsp_ready_i,
                        dma_slv_rsp_ready_i, ext_slv_rsp_ready_i}),
    .tgt_req_o        ({ext_mst_req_o, periph_mst_req_o, tcdm_mst_req_o}),
    .tgt_req_valid_o  ({ext_mst_req_valid_o, periph_mst_req_valid_o, tcdm_mst_req_valid_o}),
    .tgt_req_ready_i  ({ext_mst_req_ready_i, periph_mst_req_ready_i, tcdm_mst_req_ready_i}),
    .tgt_rsp_i        ({ext_mst_rsp_i, periph_mst_rsp_i, tcdm_mst_rsp_i}),
    .tgt_rsp_valid_i  ({ext_mst_rsp_valid_i, periph_mst_rsp_valid_i, tcdm_mst_rsp_valid_i}),
    .tgt_rsp_ready_o  ({ext_mst_rsp_ready_o, periph_mst_rsp_ready_o, tcdm_mst_rsp_ready_o})
  );

endmodule

`default_nettype wire

/* cluster_bus_xbar.sv */
// cluster bus crossbar, initiators to targets with round-robin arbitration
// target IDs carry the initiator index on top, responses return by that index
// decode errors are answered locally per initiator
`timescale 1ns/1ps
`default_nettype none
`include "cluster_bus_defs.svh"

module cluster_bus_xbar (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic [5:0]                                   cluster_id_i,
  input  cluster_bus_pkg::init_req_t [`CB_NB_INIT-1:0] init_req_i,
  input  logic [`CB_NB_INIT-1:0]                       init_req_valid_i,
  output logic [`CB_NB_INIT-1:0]                       init_req_ready_o,
  output cluster_bus_pkg::init_rsp_t [`CB_NB_INIT-1:0] init_rsp_o,
  output logic [`CB_NB_INIT-1:0]                       init_rsp_valid_o,
  input  logic [`CB_NB_INIT-1:0]                       init_rsp_ready_i,
  output cluster_bus_pkg::tgt_req_t [`CB_NB_TGT-1:0]   tgt_req_o,
  output logic [`CB_NB_TGT-1:0]                        tgt_req_valid_o,
  input  logic [`CB_NB_TGT-1:0]                        tgt_req_ready_i,
  input  cluster_bus_pkg::tgt_rsp_t [`CB_NB_TGT-1:0]   tgt_rsp_i,
  input  logic [`CB_NB_TGT-1:0]                        tgt_rsp_valid_i,
  output logic [`CB_NB_TGT-1:0]                        tgt_rsp_ready_o
);
  import cluster_bus_pkg::*;

  localparam int unsigned NB_INIT = `CB_NB_INIT;
  localparam int unsigned NB_TGT = `CB_NB_TGT;
  // response sources are the targets plus the error responder
  localparam int unsigned NB_SRC = NB_TGT + 1;
  localparam int unsigned IDX_W = `CB_ID_OUT_W - `CB_ID_IN_W;

  tgt_idx_t [NB_INIT-1:0]              dec_tgt;
  logic [NB_INIT-1:0]                  err_accept;
  logic [NB_INIT-1:0]                  err_done;
  logic [NB_INIT-1:0]                  err_pend_q;
  logic [NB_INIT-1:0][`CB_ID_IN_W-1:0] err_id_q;
  logic [NB_TGT-1:0][NB_INIT-1:0]      req_arb_req;
  logic [NB_TGT-1:0][NB_INIT-1:0]      req_gnt;
  logic [NB_TGT-1:0]                   req_spill_ready;
  logic [NB_INIT-1:0][NB_SRC-1:0]      rsp_arb_req;
  logic [NB_INIT-1:0][NB_SRC-1:0]      rsp_gnt;
  logic [NB_INIT-1:0]                  rsp_spill_ready;

  function automatic tgt_req_t extend_req(init_req_t req, logic [IDX_W-1:0] idx);
    tgt_req_t ext;
    ext.addr = req.addr;
    ext.we = req.we;
    ext.wdata = req.wdata;
    ext.be = req.be;
    ext.id = {idx, req.id};
    return ext;
  endfunction

  for (genvar i = 0; i < NB_INIT; i++) begin : gen_dec
    cluster_addr_decoder u_dec (
      .addr_i       (init_req_i[i].addr),
      .cluster_id_i (cluster_id_i),
      .tgt_o        (dec_tgt[i])
    );
    // one outstanding error per initiator
    assign err_accept[i] = init_req_valid_i[i] && (dec_tgt[i] == TGT_NONE) && !err_pend_q[i];
  end

  // request side, one arbiter and one cut register per target
  for (genvar t = 0; t < NB_TGT; t++) begin : gen_tgt
    tgt_req_t mux_req;

    for (genvar i = 0; i < NB_INIT; i++) begin : gen_req
      // a full spill register blocks all grants
      assign req_arb_req[t][i] = init_req_valid_i[i] && req_spill_ready[t] &&
                                 (dec_tgt[i] == tgt_idx_t'(t));
    end

    rr_arbiter #(
      .N (NB_INIT)
    ) u_req_arb (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .req_i    (req_arb_req[t]),
      .accept_i (req_spill_ready[t]),
      .gnt_o    (req_gnt[t])
    );

    always_comb begin
      mux_req = '0;
      for (int i = 0; i < NB_INIT; i++) begin
        if (req_gnt[t][i]) begin
          mux_req = extend_req(init_req_i[i], IDX_W'(i));
        end
      end
    end

    bus_spill_reg #(
      .payload_t (tgt_req_t)
    ) u_req_spill (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (|req_gnt[t]),
      .ready_o (req_spill_ready[t]),
      .data_i  (mux_req),
      .valid_o (tgt_req_valid_o[t]),
      .ready_i (tgt_req_ready_i[t]),
      .data_o  (tgt_req_o[t])
    );
  end

  always_comb begin
    for (int i = 0; i < NB_INIT; i++) begin
      init_req_ready_o[i] = err_accept[i];
      for (int t = 0; t < NB_TGT; t++) begin
        init_req_ready_o[i] = init_req_ready_o[i] | req_gnt[t][i];
      end
    end
  end

  // response side, one arbiter and one cut register per initiator
  for (genvar i = 0; i < NB_INIT; i++) begin : gen_init
    init_rsp_t mux_rsp;

    for (genvar t = 0; t < NB_TGT; t++) begin : gen_src
      assign rsp_arb_req[i][t] = tgt_rsp_valid_i[t] && rsp_spill_ready[i] &&
                                 (tgt_rsp_i[t].id[`CB_ID_OUT_W-1 -: IDX_W] == IDX_W'(i));
    end
    assign rsp_arb_req[i][NB_TGT] = err_pend_q[i] && rsp_spill_ready[i];
    assign err_done[i] = rsp_gnt[i][NB_TGT];

    rr_arbiter #(
      .N (NB_SRC)
    ) u_rsp_arb (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .req_i    (rsp_arb_req[i]),
      .accept_i (rsp_spill_ready[i]),
      .gnt_o    (rsp_gnt[i])
    );

    always_comb begin
      mux_rsp = '0;
      // error response has zero data and the original ID
      if (rsp_gnt[i][NB_TGT]) begin
        mux_rsp.err = 1'b1;
        mux_rsp.id = err_id_q[i];
      end
      for (int t = 0; t < NB_TGT; t++) begin
        if (rsp_gnt[i][t]) begin
          mux_rsp.rdata = tgt_rsp_i[t].rdata;
          mux_rsp.err = tgt_rsp_i[t].err;
          mux_rsp.id = tgt_rsp_i[t].id[`CB_ID_IN_W-1:0];
        end
      end
    end

    bus_spill_reg #(
      .payload_t (init_rsp_t)
    ) u_rsp_spill (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (|rsp_gnt[i]),
      .ready_o (rsp_spill_ready[i]),
      .data_i  (mux_rsp),
      .valid_o (init_rsp_valid_o[i]),
      .ready_i (init_rsp_ready_i[i]),
      .data_o  (init_rsp_o[i])
    );
  end

  always_comb begin
    tgt_rsp_ready_o = '0;
    for (int t = 0; t < NB_TGT; t++) begin
      for (int i = 0; i < NB_INIT; i++) begin
        tgt_rsp_ready_o[t] = tgt_rsp_ready_o[t] | rsp_gnt[i][t];
      end
    end
  end

  // error responder state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_pend_q <= '0;
    end else begin
      err_pend_q <= (err_pend_q | err_accept) & ~err_done;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NB_INIT; i++) begin
      if (err_accept[i]) begin
        err_id_q[i] <= init_req_i[i].id;
      end
    end
  end

endmodule

`default_nettype wire

/* cluster_addr_decoder.sv */
// address decoder for the cluster window
// picks tcdm, periph or ext, and flags the hole between tcdm and periph
`timescale 1ns/1ps
`default_nettype none
`include "cluster_bus_defs.svh"

module cluster_addr_decoder (
  input  logic [`CB_ADDR_W-1:0]   addr_i,
  input  logic [5:0]              cluster_id_i,
  output cluster_bus_pkg::tgt_idx_t tgt_o
);
  import cluster_bus_pkg::*;

  // one window per cluster, windows are packed back to back
  localparam int unsigned WIN_SHIFT = $clog2(`CB_CLUSTER_SPAN);

  logic [`CB_ADDR_W-1:0] base;
  logic [`CB_ADDR_W-1:0] offset;
  logic                  in_window;

  assign base = `CB_CLUSTER_BASE + (`CB_ADDR_W'(cluster_id_i) << WIN_SHIFT);
  assign offset = addr_i - base;
  // offset compare keeps the upper bound free of overflow
  assign in_window = (addr_i >= base) && (offset < `CB_CLUSTER_SPAN);

  always_comb begin
    if (!in_window) begin
      tgt_o = TGT_EXT;
    end else if (offset < `CB_TCDM_SIZE) begin
      tgt_o = TGT_TCDM;
    end else if (offset >= `CB_PERIPH_OFS) begin
      tgt_o = TGT_PERIPH;
    end else begin
      // unmapped gap after the tcdm
      tgt_o = TGT_NONE;
    end
  end

endmodule

`default_nettype wire

/* bus_spill_reg.sv */
// two-slot skid buffer that registers both the forward and the ready path
// one item per cycle passes through while the output drains
`timescale 1ns/1ps
`default_nettype none

module bus_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // slot a drives the output, slot b holds an item caught during a stall
  logic     a_full_q;
  logic     b_full_q;
  payload_t a_data_q;
  payload_t b_data_q;
  logic     push;
  logic     pop;

  assign ready_o = !b_full_q;
  assign valid_o = a_full_q;
  assign data_o = a_data_q;
  assign push = valid_i && ready_o;
  assign pop = a_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else if (b_full_q) begin
      // b refills a on a pop, so a stays full
      if (pop) begin
        b_full_q <= 1'b0;
      end
    end else if (push && a_full_q && !pop) begin
      b_full_q <= 1'b1;
    end else begin
      a_full_q <= push | (a_full_q & ~pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_full_q) begin
      if (pop) begin
        a_data_q <= b_data_q;
      end
    end else if (push) begin
      if (a_full_q && !pop) begin
        b_data_q <= data_i;
      end else begin
        a_data_q <= data_i;
      end
    end
  end

endmodule

`default_nettype wire

/* rr_arbiter.sv */
// round-robin arbiter with a combinational one-hot grant
// the priority pointer moves past the winner once the grant is taken
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
  parameter int unsigned N = 4
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic [N-1:0] req_i,
  input  logic         accept_i,
  output logic [N-1:0] gnt_o
);

  localparam int unsigned PTR_W = (N > 1) ? $clog2(N) : 1;

  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] win;
  logic             found;
  int unsigned      cand;

  // first requester at or after the pointer wins
  always_comb begin
    gnt_o = '0;
    win = ptr_q;
    found = 1'b0;
    cand = 0;
    for (int unsigned k = 0; k < N; k++) begin
      cand = (ptr_q + k) % N;
      if (!found && req_i[cand]) begin
        found = 1'b1;
        win = PTR_W'(cand);
        gnt_o[cand] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (accept_i && found) begin
      ptr_q <= (win == PTR_W'(N - 1)) ? '0 : win + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* cluster_bus_pkg.sv */
// cluster bus payload types
// initiator side structs carry the short ID, target side structs the extended one
`default_nettype none
`include "cluster_bus_defs.svh"

package cluster_bus_pkg;

  // TGT_NONE marks the hole inside the window
  typedef enum logic [1:0] {
    TGT_TCDM   = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_EXT    = 2'd2,
    TGT_NONE   = 2'd3
  } tgt_idx_t;

  typedef struct packed {
    logic [`CB_ADDR_W-1:0]   addr;
    logic                    we;
    logic [`CB_DATA_W-1:0]   wdata;
    logic [3:0]              be;
    logic [`CB_ID_IN_W-1:0]  id;
  } init_req_t;

  typedef struct packed {
    logic [`CB_ADDR_W-1:0]   addr;
    logic                    we;
    logic [`CB_DATA_W-1:0]   wdata;
    logic [3:0]              be;
    logic [`CB_ID_OUT_W-1:0] id;
  } tgt_req_t;

  typedef struct packed {
    logic [`CB_DATA_W-1:0]   rdata;
    logic                    err;
    logic [`CB_ID_IN_W-1:0]  id;
  } init_rsp_t;

  typedef struct packed {
    logic [`CB_DATA_W-1:0]   rdata;
    logic                    err;
    logic [`CB_ID_OUT_W-1:0] id;
  } tgt_rsp_t;

endpackage

`default_nettype wire

/* cluster_bus_defs.svh */
// cluster bus widths, port counts and address map constants
`ifndef CLUSTER_BUS_DEFS_SVH
`define CLUSTER_BUS_DEFS_SVH

// payload widths
`define CB_ADDR_W 32
`define CB_DATA_W 32
`define CB_ID_IN_W 4
// initiator index sits above the initiator ID at the targets
`define CB_ID_OUT_W (`CB_ID_IN_W + 2)

// port counts
`define CB_NB_INIT 4
`define CB_NB_TGT 3

// address map, window offsets are relative to the cluster base
`define CB_CLUSTER_BASE 32'h1000_0000
`define CB_CLUSTER_SPAN 32'h0040_0000
`define CB_PERIPH_OFS 32'h0020_0000
`define CB_TCDM_SIZE 32'h0001_0000

`endif
